// File: build.f
+incdir+tests
logic/serial_pkg.sv
logic/alu_op_pkg.sv
logic/alu_ctrl_regs.sv
logic/bit_sequencer.sv
logic/serial_shift.sv
logic/serial_alu.sv
logic/operand_sreg.sv
logic/serial_alu_top.sv
tests/tb_serial_alu.sv

// File: logic/alu_ctrl_regs.sv
`timescale 1ns/1ps

module alu_ctrl_regs (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_start,
   input  logic                  i_busy,
   input  alu_op_pkg::alu_op_e   i_op,
   output alu_op_pkg::alu_ctrl_t o_ctrl
);
   import alu_op_pkg::*;

   alu_op_e op_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         op_q <= OP_ADD;
      else if (i_start && !i_busy)
         op_q <= i_op;
   end

   always_comb begin
      o_ctrl = '0;
      case (op_q)
         OP_ADD:  o_ctrl.rd_sel = 4'b0001;
         OP_SUB: begin
            o_ctrl.sub    = 1'b1;
            o_ctrl.rd_sel = 4'b0001;
         end
         OP_AND: begin
            o_ctrl.bool_op = 2'd3;
            o_ctrl.rd_sel  = 4'b1000;
         end
         OP_OR: begin
            o_ctrl.bool_op = 2'd2;
            o_ctrl.rd_sel  = 4'b1000;
         end
         OP_XOR:  o_ctrl.rd_sel = 4'b1000;
         OP_SLT, OP_SLTU, OP_EQ: begin
            o_ctrl.sub      = 1'b1; // Compare on a - b
            o_ctrl.cmp_sig  = (op_q == OP_SLT);
            o_ctrl.cmp_eq   = (op_q == OP_EQ);
            o_ctrl.rd_sel   = 4'b0100;
            o_ctrl.two_pass = 1'b1;
         end
         OP_SLL, OP_SRL, OP_SRA: begin
            o_ctrl.shift_op  = 1'b1;
            o_ctrl.sh_right  = (op_q != OP_SLL);
            o_ctrl.sh_signed = (op_q == OP_SRA);
            o_ctrl.rd_sel    = 4'b0010;
            o_ctrl.two_pass  = 1'b1;
         end
         default: o_ctrl.rd_sel = 4'b0001;
      endcase
   end

endmodule

// File: logic/alu_op_pkg.sv
package alu_op_pkg;

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLT  = 4'd5,
      OP_SLTU = 4'd6,
      OP_EQ   = 4'd7,
      OP_SLL  = 4'd8,
      OP_SRL  = 4'd9,
      OP_SRA  = 4'd10
   } alu_op_e;

   typedef struct packed {
      logic       sub;
      logic       shift_op;
      logic [1:0] bool_op;   // 0 xor, 1 xnor, 2 or, 3 and
      logic       cmp_eq;
      logic       cmp_sig;
      logic       sh_right;
      logic       sh_signed;
      logic [3:0] rd_sel;    // {bool, cmp, shift, add}
      logic       two_pass;
   } alu_ctrl_t;

endpackage

// File: logic/bit_sequencer.sv
`timescale 1ns/1ps

module bit_sequencer (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_start,
   input  alu_op_pkg::alu_ctrl_t i_ctrl,
   input  logic                  i_sh_stall,
   input  logic                  i_sh_done,
   output logic                  o_load,
   output logic                  o_en,
   output logic                  o_cnt0,
   output logic                  o_cnt_done,
   output logic                  o_shamt_en,
   output logic                  o_pass2,
   output logic                  o_busy,
   output logic                  o_done
);
   import serial_pkg::*;

   typedef enum logic [2:0] {IDLE, PASS1, SKIP, PASS2, DONE} state_e;

   state_e state;
   cnt_t   cnt;
   logic   counting;

   assign counting   = (state == PASS1) || (state == PASS2);
   assign o_load     = i_start && (state == IDLE);
   assign o_busy     = (state != IDLE);
   assign o_done     = (state == DONE);
   assign o_pass2    = (state == SKIP) || (state == PASS2);
   assign o_cnt0     = (cnt == '0);
   assign o_cnt_done = counting && (cnt == CNT_LAST);
   // Stall cycles still emit a zero bit but the ALU does no work
   assign o_en       = (state == PASS1) || (state == SKIP) || ((state == PASS2) && !i_sh_stall);
   assign o_shamt_en = (state == PASS1) && i_ctrl.shift_op && (cnt < cnt_t'(SHAMT_BITS));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         if (o_load)
            cnt <= '0;
         else if (counting)
            cnt <= cnt + 1'b1; // Wraps to zero at the end of a pass
         case (state)
            IDLE:  if (i_start) state <= PASS1;
            PASS1: if (o_cnt_done) begin
               if (!i_ctrl.two_pass)
                  state <= DONE;
               else if (i_ctrl.sh_right && !i_sh_done)
                  state <= SKIP;
               else
                  state <= PASS2;
            end
            SKIP:  if (i_sh_done) state <= PASS2;
            PASS2: if (o_cnt_done) state <= DONE;
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// File: logic/operand_sreg.sv
`timescale 1ns/1ps

module operand_sreg (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_load,
   input  serial_pkg::word_t i_d,
   input  logic              i_shift,
   input  logic              i_sin,
   output logic              o_sout,
   output serial_pkg::word_t o_q
);
   import serial_pkg::*;

   word_t q;

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         q <= '0;
      else if (i_load)
         q <= i_d;
      else if (i_shift)
         q <= {i_sin, q[XLEN-1:1]}; // LSB leaves first
   end

   assign o_sout = q[0];
   assign o_q    = q;

endmodule

// File: logic/serial_alu.sv
`timescale 1ns/1ps

module serial_alu (
   input  logic                  clk,
   input  logic                  i_en,
   input  logic                  i_cnt0,
   input  logic                  i_cnt_done,
   input  logic                  i_shamt_en,
   input  logic                  i_pass2,
   input  alu_op_pkg::alu_ctrl_t i_ctrl,
   input  logic                  i_sh_stall,
   input  logic                  i_rs1,
   input  logic                  i_rs2,
   output serial_pkg::shamt_t    o_shamt,
   output logic                  o_cmp,
   output logic                  o_rd
);
   import serial_pkg::*;

   // Indexed by {bool_op, rs1, rs2}
   localparam logic [15:0] BOOL_LUT = 16'h8E96;

   logic   add_a;
   logic   add_b;
   logic   add_cin;
   logic   add_cy;
   logic   add_cy_r;
   logic   result_add;
   logic   result_lt;
   logic   result_eq;
   logic   result_sh;
   logic   result_bool;
   logic   eq_r;
   logic   cmp_r;
   shamt_t shamt;

   assign add_a = i_rs1 & ~i_ctrl.shift_op;
   assign add_b = i_rs2 ^ i_ctrl.sub;
   // Sub bit is the carry in on the first bit of a pass
   assign add_cin = i_cnt0 ? i_ctrl.sub : add_cy_r;
   assign {add_cy, result_add} = add_a + add_b + add_cin;

   // Sign bit of the 33-bit difference, only meaningful on the last bit
   assign result_lt = (i_rs1 & i_ctrl.cmp_sig) ^ ~(i_rs2 & i_ctrl.cmp_sig) ^ add_cy;

   assign result_eq   = ~result_add & eq_r;
   assign result_sh   = i_rs1 & ~i_sh_stall;
   assign result_bool = BOOL_LUT[{i_ctrl.bool_op, i_rs1, i_rs2}];

   assign o_rd = (i_ctrl.rd_sel[0] & result_add) |
                 (i_ctrl.rd_sel[1] & result_sh) |
                 (i_ctrl.rd_sel[2] & cmp_r & i_cnt0 & i_pass2) |
                 (i_ctrl.rd_sel[3] & result_bool);

   assign o_cmp   = cmp_r;
   assign o_shamt = shamt;

   always_ff @(posedge clk) begin
      add_cy_r <= add_cy;
      eq_r     <= result_eq | ~i_en;

      if (i_en && i_cnt_done && !i_pass2)
         cmp_r <= i_ctrl.cmp_eq ? result_eq : result_lt;

      // Low bits of B arrive first
      if (i_shamt_en)
         shamt <= {i_rs2, shamt[$bits(shamt_t)-1:1]};
   end

endmodule

// File: logic/serial_alu_top.sv
`timescale 1ns/1ps

module serial_alu_top (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_start,
   input  alu_op_pkg::alu_op_e i_op,
   input  serial_pkg::word_t   i_a,
   input  serial_pkg::word_t   i_b,
   output logic                o_busy,
   output logic                o_done,
   output serial_pkg::word_t   o_result,
   output logic                o_cmp
);
   import serial_pkg::*;
   import alu_op_pkg::*;

   alu_ctrl_t ctrl;
   shamt_t    shamt;
   word_t     a_q;
   logic      load, en, cnt0, cnt_done, shamt_en, pass2;
   logic      sh_stall, sh_done, rd, a_sout, b_sout;

   // A rotates in pass 1 so shifts still see it whole in pass 2
   wire a_sin     = pass2 ? (ctrl.sh_signed & a_q[XLEN-1]) : a_sout;
   wire res_shift = en | sh_stall;

   alu_ctrl_regs u_ctrl (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_busy(o_busy),
      .i_op(i_op), .o_ctrl(ctrl));

   bit_sequencer u_seq (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_ctrl(ctrl),
      .i_sh_stall(sh_stall), .i_sh_done(sh_done), .o_load(load), .o_en(en),
      .o_cnt0(cnt0), .o_cnt_done(cnt_done), .o_shamt_en(shamt_en),
      .o_pass2(pass2), .o_busy(o_busy), .o_done(o_done));

   serial_shift u_shift (
      .clk(clk), .i_rst_n(i_rst_n), .i_load(cnt_done), .i_shamt(shamt),
      .i_right(ctrl.sh_right), .i_active(pass2 & ctrl.shift_op), .o_sh_stall(sh_stall),
      .o_sh_done(sh_done));

   serial_alu u_alu (
      .clk(clk), .i_en(en), .i_cnt0(cnt0), .i_cnt_done(cnt_done),
      .i_shamt_en(shamt_en), .i_pass2(pass2), .i_ctrl(ctrl), .i_sh_stall(sh_stall),
      .i_rs1(a_sout), .i_rs2(b_sout), .o_shamt(shamt), .o_cmp(o_cmp), .o_rd(rd));

   operand_sreg u_a_reg (
      .clk(clk), .i_rst_n(i_rst_n), .i_load(load), .i_d(i_a), .i_shift(en),
      .i_sin(a_sin), .o_sout(a_sout), .o_q(a_q));

   operand_sreg u_b_reg (
      .clk(clk), .i_rst_n(i_rst_n), .i_load(load), .i_d(i_b), .i_shift(en),
      .i_sin(1'b0), .o_sout(b_sout), .o_q());

   operand_sreg u_res_reg (
      .clk(clk), .i_rst_n(i_rst_n), .i_load(load), .i_d('0), .i_shift(res_shift),
      .i_sin(rd), .o_sout(), .o_q(o_result));

endmodule

// File: logic/serial_pkg.sv
package serial_pkg;

   // Datapath word width
   localparam int XLEN = 32;

   // Bits needed to index one word, also the shift amount width
   localparam int IDX_W = $clog2(XLEN);

   // Operand B bits that carry the shift amount
   localparam int SHAMT_BITS = IDX_W;

   localparam logic [IDX_W-1:0] CNT_LAST = IDX_W'(XLEN - 1);

   typedef logic [XLEN-1:0]  word_t;
   typedef logic [IDX_W-1:0] shamt_t;
   typedef logic [IDX_W-1:0] cnt_t;

endpackage

// File: logic/serial_shift.sv
`timescale 1ns/1ps

module serial_shift (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_load,
   input  serial_pkg::shamt_t   i_shamt,
   input  logic                 i_right,
   input  logic                 i_active,
   output logic                 o_sh_stall,
   output logic                 o_sh_done
);
   import serial_pkg::*;

   shamt_t count;

   // Left shifts insert zeros at the bottom while the count runs
   assign o_sh_stall = i_active && !i_right && (count != '0);

   // Looks one cycle ahead so the last dropped bit and the
   // switch to pass 2 fall in the same cycle
   always_comb begin
      if (i_load)
         o_sh_done = (i_shamt == '0);
      else
         o_sh_done = (count <= shamt_t'(1));
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         count <= '0;
      else if (i_load)
         count <= i_shamt;
      else if (i_active && (count != '0))
         count <= count - 1'b1;
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the serial ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_serial_alu \
   -f build.f --Mdir "$OBJ" -o tb_serial_alu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/tb_serial_alu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Flag only counts when cmp_chk is set
typedef struct packed {
   logic  cmp_chk;
   logic  flag;
   word_t word;
} expect_t;

function automatic expect_t ref_result(alu_op_e op, word_t a, word_t b);
   expect_t e;
   shamt_t  sh;
   e  = '0;
   sh = b[4:0]; // Upper bits of B are ignored
   case (op)
      OP_ADD:  e.word = a + b;
      OP_SUB:  e.word = a - b;
      OP_AND:  e.word = a & b;
      OP_OR:   e.word = a | b;
      OP_XOR:  e.word = a ^ b;
      OP_SLT, OP_SLTU, OP_EQ: begin
         e.cmp_chk = 1'b1;
         if (op == OP_SLT)
            e.flag = ($signed(a) < $signed(b));
         else if (op == OP_SLTU)
            e.flag = (a < b);
         else
            e.flag = (a == b);
         e.word = {31'b0, e.flag}; // Zero extended
      end
      OP_SLL:  e.word = a << sh;
      OP_SRL:  e.word = a >> sh;
      OP_SRA:  e.word = $signed(a) >>> sh;
      default: e.word = '0;
   endcase
   return e;
endfunction

`endif

// File: tests/tb_serial_alu.sv
`timescale 1ns/1ps

module tb_serial_alu;
   import serial_pkg::*;
   import alu_op_pkg::*;

   `include "tb_ref_model.svh"

   typedef struct packed {
      alu_op_e op;
      word_t   a;
      word_t   b;
   } req_t;

   localparam int DONE_TIMEOUT = 200;

   logic    clk;
   logic    rst_n;
   logic    start;
   alu_op_e op;
   word_t   a;
   word_t   b;
   logic    busy;
   logic    done;
   word_t   result;
   logic    cmp;

   req_t    pending[$];
   integer  seed = 53091;
   int      checked;
   int      errors;
   int      errors_at_start;
   int      tests_passed;
   int      tests_failed;
   string   test_name;

   serial_alu_top UUT (
      .clk(clk), .i_rst_n(rst_n), .i_start(start), .i_op(op), .i_a(a), .i_b(b),
      .o_busy(busy), .o_done(done), .o_result(result), .o_cmp(cmp));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Checks each finished request against the reference
   always @(negedge clk) begin
      req_t    req;
      expect_t want;
      alu_op_e cur_op;
      if (done) begin
         assert (pending.size() > 0) else begin
            $display("o_done pulsed at %0t with no request pending", $time);
            errors++;
         end
         if (pending.size() > 0) begin
            req    = pending.pop_front();
            cur_op = req.op;
            want   = ref_result(req.op, req.a, req.b);
            assert (result == want.word) else begin
               $display("ERR %0t: %s result expected %h actual %h",
                        $time, cur_op.name(), want.word, result);
               errors++;
            end
            if (want.cmp_chk) begin
               assert (cmp == want.flag) else begin
                  $display("ERR %0t: %s o_cmp expected %b actual %b",
                           $time, cur_op.name(), want.flag, cmp);
                  errors++;
               end
            end
            checked++;
         end
      end
   end

   task automatic run_op(input alu_op_e op_in, input word_t a_in, input word_t b_in,
                         input bit extra_start = 1'b0);
      req_t req;
      int   target;
      int   cycles;
      target = checked + 1;
      req.op = op_in;
      req.a  = a_in;
      req.b  = b_in;
      @(posedge clk);
      #5;
      start = 1'b1;
      op    = op_in;
      a     = a_in;
      b     = b_in;
      pending.push_back(req);
      @(posedge clk);
      #5;
      start  = 1'b0;
      assert (busy) else begin
         $display("ERR %0t: %s o_busy expected 1 actual 0", $time, op_in.name());
         errors++;
      end
      cycles = 0;
      while (checked < target && cycles < DONE_TIMEOUT) begin
         @(posedge clk);
         #5;
         cycles++;
         if (extra_start && cycles == 3) begin
            start = 1'b1; // Should be ignored while busy
            op    = OP_SUB;
            a     = ~a_in;
            b     = a_in;
         end else begin
            start = 1'b0;
         end
      end
      if (checked < target) begin
         $display("Timed out after %0d cycles waiting for o_done on %s",
                  DONE_TIMEOUT, op_in.name());
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      if (errors == errors_at_start) begin
         tests_passed++;
         $display("PASS %s", test_name);
      end else begin
         tests_failed++;
         $display("FAIL %s (%0d errors)", test_name, errors - errors_at_start);
      end
   endtask

   initial begin
      int    k;
      word_t x;
      word_t y;
      rst_n        = 1'b0;
      start        = 1'b0;
      op           = OP_ADD;
      a            = '0;
      b            = '0;
      checked      = 0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      #5;
      rst_n = 1'b1;

      start_test("reset");
      @(negedge clk);
      assert (!busy && !done && result == '0) else begin
         $display("ERR %0t: outputs not idle after reset, busy %b done %b result %h",
                  $time, busy, done, result);
         errors++;
      end
      finish_test();

      start_test("add_sub");
      run_op(OP_ADD, 32'hFFFF_FFFF, 32'h1);
      run_op(OP_SUB, 32'h0, 32'h1);
      for (k = 0; k < 8; k++) begin
         x = $random(seed);
         y = $random(seed);
         run_op(OP_ADD, x, y);
         run_op(OP_SUB, x, y);
      end
      finish_test();

      start_test("boolean");
      for (k = 0; k < 8; k++) begin
         x = $random(seed);
         y = $random(seed);
         run_op(OP_AND, x, y);
         run_op(OP_OR, x, y);
         run_op(OP_XOR, x, y);
      end
      finish_test();

      start_test("compare");
      run_op(OP_SLT, 32'h8000_0000, 32'h1);
      run_op(OP_SLTU, 32'h8000_0000, 32'h1);
      run_op(OP_SLT, 32'h1, 32'h8000_0000);
      run_op(OP_SLTU, 32'h1, 32'h8000_0000);
      x = $random(seed);
      run_op(OP_EQ, x, x);
      run_op(OP_SLT, x, x);
      run_op(OP_EQ, x, x ^ 32'h1);
      for (k = 0; k < 8; k++) begin
         x = $random(seed);
         y = $random(seed);
         run_op(OP_SLT, x, y);
         run_op(OP_SLTU, x, y);
         run_op(OP_EQ, x, y);
      end
      finish_test();

      start_test("shift");
      x = 32'hB4C3_96E5; // Negative operand
      for (k = 0; k < 32; k++) begin
         y = ($random(seed) & ~32'h1F) | k; // Junk above the low five bits
         run_op(OP_SLL, x, y);
         run_op(OP_SRL, x, y);
         run_op(OP_SRA, x, y);
      end
      run_op(OP_SLTU, x, y); // Compare right after a long shift
      finish_test();

      start_test("start_while_busy");
      run_op(OP_ADD, 32'h1234_5678, 32'h0F0F_0F0F, 1'b1);
      run_op(OP_SRA, 32'h8000_0010, 32'h4, 1'b1);
      finish_test();

      $display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
               tests_passed, tests_failed, checked, errors);
      if (tests_failed == 0 && errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule
